// ==== verilog/ahb_port_pkg.sv ====
// shared AHB types for the slave port; address and data are fixed at 32 bits and split or retry are not supported
package ahb_port_pkg;

   //////////////////////////////
   // bus widths
   //////////////////////////////

   // byte address
   typedef logic [31:0] haddr_t;
   // read or write data word
   typedef logic [31:0] hdata_t;
   // transfer type
   typedef logic [1:0]  htrans_t;
   // transfer size
   typedef logic [2:0]  hsize_t;
   // burst type
   typedef logic [2:0]  hburst_t;
   // slave response
   typedef logic [1:0]  hresp_t;

   //////////////////////////////
   // encodings
   //////////////////////////////

   // bit 0 set means the transfer continues a burst
   localparam htrans_t HTRANS_IDLE   = 2'b00;
   localparam htrans_t HTRANS_BUSY   = 2'b01;
   localparam htrans_t HTRANS_NONSEQ = 2'b10;
   localparam htrans_t HTRANS_SEQ    = 2'b11;

   localparam hresp_t  HRESP_OKAY    = 2'b00;

   //////////////////////////////
   // grouped signals
   //////////////////////////////

   // address-phase control of one master, or the one sent to the slave
   typedef struct packed {
      haddr_t  haddr;
      htrans_t htrans;
      hsize_t  hsize;
      hburst_t hburst;
      logic    hwrite;
   } ahb_ctrl_t;

   // what one master gets back
   typedef struct packed {
      logic    hready;
      hresp_t  hresp;
      hdata_t  hrdata;
   } ahb_resp_t;

   // per-master path through the port
   typedef enum logic [1:0] {
      PATH_IDLE = 2'd0,
      PATH_WAIT = 2'd1,
      PATH_DATA = 2'd2
   } path_state_t;

endpackage

// ==== verilog/port_arbiter.sv ====
// grant is combinational from req and only one master is granted; the pointer moves only when hready is high
`timescale 1ns/100ps

module port_arbiter #(
   parameter int NB_MASTER_PORT = 2,
   parameter int PRIO_WIDTH     = 1
) (
   input  logic                      hclk,
   input  logic                      resetn,
   input  logic                      round_robin,
   input  logic [PRIO_WIDTH-1:0]     priority_level [NB_MASTER_PORT],
   input  logic [NB_MASTER_PORT-1:0] req,
   input  ahb_port_pkg::ahb_ctrl_t   mx_ctrl        [NB_MASTER_PORT],
   input  logic                      hready,
   output logic [NB_MASTER_PORT-1:0] grant
);

   // index of the last owner, fits in the priority width
   logic [PRIO_WIDTH-1:0] last_idx;
   logic [PRIO_WIDTH-1:0] win_idx;
   logic                  win_vld;

   //////////////////////////////
   // winner selection
   //////////////////////////////
   always_comb begin
      int                    idx;
      logic [PRIO_WIDTH-1:0] best_lvl;
      win_idx  = last_idx;
      win_vld  = 1'b0;
      best_lvl = '0;
      idx      = 0;
      if (req[last_idx] && mx_ctrl[last_idx].htrans[0]) begin
         // SEQ or BUSY from the owner keeps the burst together
         win_vld = 1'b1;
      end else if (round_robin) begin
         // scan upward from the owner with wrap
         for (int k = 1; k <= NB_MASTER_PORT; k++) begin
            idx = (int'(last_idx) + k) % NB_MASTER_PORT;
            if (!win_vld && req[idx]) begin
               win_vld = 1'b1;
               win_idx = PRIO_WIDTH'(idx);
            end
         end
      end else begin
         // strictly greater so a tie stays with the lower index
         for (int k = 0; k < NB_MASTER_PORT; k++) begin
            if (req[k] && (!win_vld || priority_level[k] > best_lvl)) begin
               win_vld  = 1'b1;
               best_lvl = priority_level[k];
               win_idx  = PRIO_WIDTH'(k);
            end
         end
      end
      grant = '0;
      if (win_vld) begin
         grant[win_idx] = 1'b1;
      end
   end

   // owner pointer
   // the first round-robin scan after reset starts at master 0
   always_ff @(posedge hclk or negedge resetn) begin
      if (!resetn) begin
         last_idx <= PRIO_WIDTH'(NB_MASTER_PORT - 1);
      end else if (hready && win_vld) begin
         last_idx <= win_idx;
      end
   end

endmodule

// ==== verilog/master_path_fsm.sv ====
// one instance per master; assumes the master holds its transfer while its hready_in is low
`timescale 1ns/100ps

module master_path_fsm #(
   parameter int NB_SLAVE_PORT = 2
) (
   input  logic                     hclk,
   input  logic                     resetn,
   // live inputs of this master
   input  logic [NB_SLAVE_PORT-1:0] hsel,
   input  ahb_port_pkg::htrans_t    htrans,
   input  logic                     hready_in,
   // from the arbiter and the slave
   input  logic                     grant,
   input  logic                     hready,
   // to the arbiter
   output logic                     req,
   // to the control mux
   output logic                     reg_ctrl,
   output logic                     ctrl_sel,
   output logic                     ctrl_from_reg,
   // to the response router
   output logic                     data_sel,
   output logic                     resp_idle
);

   ahb_port_pkg::path_state_t state;
   ahb_port_pkg::path_state_t state_nxt;
   logic                      live;

   // any slave of this port hit, a real transfer, and the master's own bus free
   assign live = (|hsel) && (htrans != ahb_port_pkg::HTRANS_IDLE) && hready_in;

   //////////////////////////////
   // state register
   //////////////////////////////
   always_ff @(posedge hclk or negedge resetn) begin
      if (!resetn) begin
         state <= ahb_port_pkg::PATH_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   //////////////////////////////
   // next state and path controls
   //////////////////////////////
   always_comb begin
      state_nxt     = state;
      req           = 1'b0;
      reg_ctrl      = 1'b0;
      ctrl_sel      = 1'b0;
      ctrl_from_reg = 1'b0;
      case (state)
         ahb_port_pkg::PATH_IDLE,
         ahb_port_pkg::PATH_DATA: begin
            req = live;
            // a data phase only ends with the slave ready
            // idle may still capture during a wait state
            if (state == ahb_port_pkg::PATH_IDLE || hready) begin
               if (live && grant && hready) begin
                  // straight through on the live control
                  ctrl_sel  = 1'b1;
                  state_nxt = ahb_port_pkg::PATH_DATA;
               end else if (live) begin
                  // refused, keep a copy and stall the master
                  reg_ctrl  = 1'b1;
                  state_nxt = ahb_port_pkg::PATH_WAIT;
               end else begin
                  state_nxt = ahb_port_pkg::PATH_IDLE;
               end
            end
         end
         ahb_port_pkg::PATH_WAIT: begin
            // master sees hready low here so live stays quiet
            req = 1'b1;
            if (grant && hready) begin
               ctrl_sel      = 1'b1;
               ctrl_from_reg = 1'b1;
               state_nxt     = ahb_port_pkg::PATH_DATA;
            end
         end
         default: begin
            state_nxt = ahb_port_pkg::PATH_IDLE;
         end
      endcase
   end

   // response side
   assign data_sel  = (state == ahb_port_pkg::PATH_DATA);
   assign resp_idle = (state == ahb_port_pkg::PATH_IDLE);

endmodule

// ==== verilog/ctrl_hold_mux.sv ====
// ctrl_sel must be one-hot or zero; with no owner the slave sees an IDLE transfer and no select
`timescale 1ns/100ps

module ctrl_hold_mux #(
   parameter int NB_MASTER_PORT = 2,
   parameter int NB_SLAVE_PORT  = 2
) (
   input  logic                      hclk,
   input  logic                      resetn,
   // from the path FSMs
   input  logic [NB_MASTER_PORT-1:0] reg_ctrl,
   input  logic [NB_MASTER_PORT-1:0] ctrl_sel,
   input  logic [NB_MASTER_PORT-1:0] ctrl_from_reg,
   // live master control
   input  logic [NB_SLAVE_PORT-1:0]  mx_hsel [NB_MASTER_PORT],
   input  ahb_port_pkg::ahb_ctrl_t   mx_ctrl [NB_MASTER_PORT],
   // toward the slave
   output logic [NB_SLAVE_PORT-1:0]  hsel,
   output ahb_port_pkg::ahb_ctrl_t   slv_ctrl
);

   // held copies of a waiting master's address phase
   logic [NB_SLAVE_PORT-1:0] hsel_d [NB_MASTER_PORT];
   ahb_port_pkg::ahb_ctrl_t  ctrl_d [NB_MASTER_PORT];

   //////////////////////////////
   // capture
   //////////////////////////////
   always_ff @(posedge hclk or negedge resetn) begin
      if (!resetn) begin
         for (int i = 0; i < NB_MASTER_PORT; i++) begin
            hsel_d[i] <= '0;
            ctrl_d[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NB_MASTER_PORT; i++) begin
            // loaded on the edge the request is refused
            if (reg_ctrl[i]) begin
               hsel_d[i] <= mx_hsel[i];
               ctrl_d[i] <= mx_ctrl[i];
            end
         end
      end
   end

   //////////////////////////////
   // address phase to the slave
   //////////////////////////////
   always_comb begin
      hsel            = '0;
      slv_ctrl        = '0;
      slv_ctrl.htrans = ahb_port_pkg::HTRANS_IDLE;
      for (int i = 0; i < NB_MASTER_PORT; i++) begin
         if (ctrl_sel[i]) begin
            // replay of held control
            if (ctrl_from_reg[i]) begin
               hsel     = hsel_d[i];
               slv_ctrl = ctrl_d[i];
            end else begin
               hsel     = mx_hsel[i];
               slv_ctrl = mx_ctrl[i];
            end
         end
      end
   end

endmodule

// ==== verilog/resp_route.sv ====
// data_sel must be one-hot or zero; masters outside their data phase get OKAY and zero data
`timescale 1ns/100ps

module resp_route #(
   parameter int NB_MASTER_PORT = 2
) (
   input  logic [NB_MASTER_PORT-1:0] data_sel,
   input  logic [NB_MASTER_PORT-1:0] resp_idle,
   input  ahb_port_pkg::hdata_t      mx_hwdata [NB_MASTER_PORT],
   // slave response
   input  logic                      hready,
   input  ahb_port_pkg::hresp_t      hresp,
   input  ahb_port_pkg::hdata_t      hrdata,
   // write data to the slave
   output ahb_port_pkg::hdata_t      hwdata,
   // per-master response
   output ahb_port_pkg::ahb_resp_t   mx_resp [NB_MASTER_PORT]
);

   //////////////////////////////
   // steering
   //////////////////////////////
   always_comb begin
      hwdata = '0;
      for (int i = 0; i < NB_MASTER_PORT; i++) begin
         if (data_sel[i]) begin
            // write data follows the data-phase owner
            hwdata            = mx_hwdata[i];
            // slave response passes straight through
            mx_resp[i].hready = hready;
            mx_resp[i].hresp  = hresp;
            mx_resp[i].hrdata = hrdata;
         end else begin
            // idle masters see ready, waiting masters are stalled
            mx_resp[i].hready = resp_idle[i];
            mx_resp[i].hresp  = ahb_port_pkg::HRESP_OKAY;
            mx_resp[i].hrdata = '0;
         end
      end
   end

endmodule

// ==== verilog/ahb_slave_port.sv ====
// one slave-side port of an AHB matrix; each mx_hready_in must be the AND of every hready that master sees
`timescale 1ns/100ps

module ahb_slave_port #(
   parameter int NB_MASTER_PORT = 2,
   parameter int NB_SLAVE_PORT  = 2,
   // enough bits to rank every master
   localparam int PRIO_WIDTH = (NB_MASTER_PORT > 1) ? $clog2(NB_MASTER_PORT) : 1
) (
   input  logic                     hclk,
   input  logic                     resetn,
   // arbitration mode and ranking
   input  logic                     round_robin,
   input  logic [PRIO_WIDTH-1:0]    priority_level [NB_MASTER_PORT],
   // master side
   input  logic [NB_SLAVE_PORT-1:0] mx_hsel       [NB_MASTER_PORT],
   input  ahb_port_pkg::ahb_ctrl_t  mx_ctrl       [NB_MASTER_PORT],
   input  ahb_port_pkg::hdata_t     mx_hwdata     [NB_MASTER_PORT],
   input  logic                     mx_hready_in  [NB_MASTER_PORT],
   output ahb_port_pkg::ahb_resp_t  mx_resp       [NB_MASTER_PORT],
   // slave side
   output logic [NB_SLAVE_PORT-1:0] hsel,
   output ahb_port_pkg::ahb_ctrl_t  slv_ctrl,
   output ahb_port_pkg::hdata_t     hwdata,
   input  logic                     hready,
   input  ahb_port_pkg::hresp_t     hresp,
   input  ahb_port_pkg::hdata_t     hrdata
);

   // per-master path controls, one bit per master
   logic [NB_MASTER_PORT-1:0] req;
   logic [NB_MASTER_PORT-1:0] grant;
   logic [NB_MASTER_PORT-1:0] reg_ctrl;
   logic [NB_MASTER_PORT-1:0] ctrl_sel;
   logic [NB_MASTER_PORT-1:0] ctrl_from_reg;
   logic [NB_MASTER_PORT-1:0] data_sel;
   logic [NB_MASTER_PORT-1:0] resp_idle;

   //////////////////////////////
   // arbitration
   //////////////////////////////
   port_arbiter #(
      .NB_MASTER_PORT (NB_MASTER_PORT),
      .PRIO_WIDTH     (PRIO_WIDTH)
   ) u_arbiter (
      .hclk           (hclk),
      .resetn         (resetn),
      .round_robin    (round_robin),
      .priority_level (priority_level),
      .req            (req),
      .mx_ctrl        (mx_ctrl),
      .hready         (hready),
      .grant          (grant)
   );

   // one path FSM per master
   for (genvar i = 0; i < NB_MASTER_PORT; i++) begin : g_path
      master_path_fsm #(
         .NB_SLAVE_PORT (NB_SLAVE_PORT)
      ) u_path (
         .hclk          (hclk),
         .resetn        (resetn),
         .hsel          (mx_hsel[i]),
         .htrans        (mx_ctrl[i].htrans),
         .hready_in     (mx_hready_in[i]),
         .grant         (grant[i]),
         .hready        (hready),
         .req           (req[i]),
         .reg_ctrl      (reg_ctrl[i]),
         .ctrl_sel      (ctrl_sel[i]),
         .ctrl_from_reg (ctrl_from_reg[i]),
         .data_sel      (data_sel[i]),
         .resp_idle     (resp_idle[i])
      );
   end

   //////////////////////////////
   // address and data paths
   //////////////////////////////
   ctrl_hold_mux #(
      .NB_MASTER_PORT (NB_MASTER_PORT),
      .NB_SLAVE_PORT  (NB_SLAVE_PORT)
   ) u_ctrl_mux (
      .hclk           (hclk),
      .resetn         (resetn),
      .reg_ctrl       (reg_ctrl),
      .ctrl_sel       (ctrl_sel),
      .ctrl_from_reg  (ctrl_from_reg),
      .mx_hsel        (mx_hsel),
      .mx_ctrl        (mx_ctrl),
      .hsel           (hsel),
      .slv_ctrl       (slv_ctrl)
   );

   resp_route #(
      .NB_MASTER_PORT (NB_MASTER_PORT)
   ) u_resp_route (
      .data_sel       (data_sel),
      .resp_idle      (resp_idle),
      .mx_hwdata      (mx_hwdata),
      .hready         (hready),
      .hresp          (hresp),
      .hrdata         (hrdata),
      .hwdata         (hwdata),
      .mx_resp        (mx_resp)
   );

endmodule

// ==== test/ahb_slave_port_properties.sv ====
// checks for the default two-master, two-slave port; all of them are off while resetn is low
`timescale 1ns/100ps

module ahb_slave_port_properties #(
   parameter int NB_MASTER_PORT = 2,
   parameter int NB_SLAVE_PORT  = 2
) (
   input logic                     hclk,
   input logic                     resetn,
   input logic [NB_SLAVE_PORT-1:0] hsel,
   input ahb_port_pkg::ahb_ctrl_t  slv_ctrl,
   input logic                     hready,
   input ahb_port_pkg::ahb_resp_t  mx_resp [NB_MASTER_PORT]
);

   // masters that currently see read data
   int nz_cnt;
   // assertion failures so far
   int fail_cnt = 0;

   always_comb begin
      nz_cnt = 0;
      for (int i = 0; i < NB_MASTER_PORT; i++) begin
         if (mx_resp[i].hrdata != '0) begin
            nz_cnt++;
         end
      end
   end

   a_hsel_onehot: assert property (@(posedge hclk) disable iff (!resetn) $onehot0(hsel))
      else begin
         $error("hsel has more than one bit set");
         fail_cnt++;
      end
   a_idle_unsel: assert property (@(posedge hclk) disable iff (!resetn)
      (hsel == '0) |-> (slv_ctrl.htrans == ahb_port_pkg::HTRANS_IDLE))
      else begin
         $error("transfer issued without a slave select");
         fail_cnt++;
      end
   // the address seen by the slave holds through a run of wait states
   a_ctrl_stable: assert property (@(posedge hclk) disable iff (!resetn)
      !hready |=> (hready || $stable(slv_ctrl)))
      else begin
         $error("slave control changed during a wait state");
         fail_cnt++;
      end
   a_one_rdata: assert property (@(posedge hclk) disable iff (!resetn) nz_cnt <= 1)
      else begin
         $error("read data routed to more than one master");
         fail_cnt++;
      end

endmodule

bind ahb_slave_port ahb_slave_port_properties #(
   .NB_MASTER_PORT (NB_MASTER_PORT),
   .NB_SLAVE_PORT  (NB_SLAVE_PORT)
) u_properties (
   .hclk     (hclk),
   .resetn   (resetn),
   .hsel     (hsel),
   .slv_ctrl (slv_ctrl),
   .hready   (hready),
   .mx_resp  (mx_resp)
);

// ==== test/tb_ahb_slave_port.sv ====
// two masters and one slave model; the slave always answers OKAY and hrdata is the address XOR a constant
`timescale 1ns/100ps

module tb_ahb_slave_port;

   localparam int S_IDLE = 0;
   localparam int S_WAIT = 1;
   localparam int S_DATA = 2;
   localparam logic [31:0] RD_KEY = 32'h5a5a_c3c3;

   logic hclk;
   logic resetn;
   logic round_robin;
   logic [0:0] priority_level [2];
   logic [1:0] mx_hsel [2];
   ahb_port_pkg::ahb_ctrl_t mx_ctrl [2];
   ahb_port_pkg::hdata_t mx_hwdata [2];
   logic mx_hready_in [2];
   ahb_port_pkg::ahb_resp_t mx_resp [2];
   logic [1:0] hsel;
   ahb_port_pkg::ahb_ctrl_t slv_ctrl;
   ahb_port_pkg::hdata_t hwdata;
   logic hready;
   ahb_port_pkg::hresp_t hresp;
   ahb_port_pkg::hdata_t hrdata;

   // stimulus staged by the tests, applied after the edge
   logic [1:0] st_hsel [2];
   ahb_port_pkg::ahb_ctrl_t st_ctrl [2];
   logic st_rdy_in [2];
   logic st_rr;
   logic [0:0] st_prio [2];
   int wait_pct;
   // reference model state
   int m_st [2];
   int n_st [2];
   logic [1:0] m_hsel_q [2];
   logic [1:0] n_hsel_q [2];
   ahb_port_pkg::ahb_ctrl_t m_ctrl_q [2];
   ahb_port_pkg::ahb_ctrl_t n_ctrl_q [2];
   int m_last;
   int n_last;
   logic [31:0] m_daddr;
   logic [31:0] n_daddr;
   logic [31:0] slv_addr_q;
   logic [31:0] slv_addr_n;
   logic seen_rdy [2];
   logic issued;
   logic [31:0] rng;
   int errors;
   int checks;
   int test_err;

   ahb_slave_port #(.NB_MASTER_PORT(2), .NB_SLAVE_PORT(2)) DUT (.*);

   initial begin
      hclk = 1'b0;
      forever #5 hclk = ~hclk;
   end

   // watchdog sized from six tests of at most 400 cycles
   initial begin
      #(6 * 400 * 10 * 2);
      $display("timeout: the tests did not finish in time");
      $display("TB FAILED");
      $finish;
   end

   function logic [31:0] xorshift();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   task automatic flag_mismatch(input string what, input logic [63:0] got, input logic [63:0] exp);
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
      test_err++;
   endtask

   // new transfer for master i, only once its last address phase was taken
   task automatic offer(input int i, input logic [1:0] sel, input logic [1:0] trans);
      if (seen_rdy[i]) begin
         st_hsel[i] = sel;
         st_ctrl[i].haddr = {xorshift() & 32'hffff_fffc};
         st_ctrl[i].htrans = trans;
         st_ctrl[i].hsize = 3'd2;
         st_ctrl[i].hburst = 3'(xorshift());
         st_ctrl[i].hwrite = xorshift() & 1;
      end
   endtask

   ////////////////////////////////
   // expected behavior and checks
   ////////////////////////////////
   task automatic predict_and_check();
      logic live [2];
      logic req [2];
      int win;
      logic [1:0] e_hsel;
      ahb_port_pkg::ahb_ctrl_t e_ctrl;
      ahb_port_pkg::ahb_resp_t e_resp;
      logic [31:0] e_wdata;
      win = -1;
      e_hsel = '0;
      e_ctrl = '0;
      e_wdata = '0;
      for (int i = 0; i < 2; i++) begin
         live[i] = (mx_hsel[i] != 0) && (mx_ctrl[i].htrans != 2'b00) && mx_hready_in[i];
         req[i] = (m_st[i] == S_WAIT) ? 1'b1 : live[i];
      end
      // burst owner keeps the bus, else round robin or priority
      if (req[m_last] && mx_ctrl[m_last].htrans[0]) win = m_last;
      else if (round_robin) win = req[1 - m_last] ? 1 - m_last : (req[m_last] ? m_last : -1);
      else if (req[0] && req[1]) win = (priority_level[1] > priority_level[0]) ? 1 : 0;
      else win = req[0] ? 0 : (req[1] ? 1 : -1);
      n_last = (hready && win >= 0) ? win : m_last;
      issued = 1'b0;
      n_daddr = m_daddr;
      for (int i = 0; i < 2; i++) begin
         n_st[i] = m_st[i];
         n_hsel_q[i] = m_hsel_q[i];
         n_ctrl_q[i] = m_ctrl_q[i];
         if (m_st[i] == S_WAIT) begin
            if (win == i && hready) begin
               issued = 1'b1;
               e_hsel = m_hsel_q[i];
               e_ctrl = m_ctrl_q[i];
               n_st[i] = S_DATA;
            end
         end else if (m_st[i] == S_IDLE || hready) begin
            if (live[i] && win == i && hready) begin
               issued = 1'b1;
               e_hsel = mx_hsel[i];
               e_ctrl = mx_ctrl[i];
               n_st[i] = S_DATA;
            end else if (live[i]) begin
               n_hsel_q[i] = mx_hsel[i];
               n_ctrl_q[i] = mx_ctrl[i];
               n_st[i] = S_WAIT;
            end else begin
               n_st[i] = S_IDLE;
            end
         end
      end
      if (issued) n_daddr = e_ctrl.haddr;
      checks++;
      if (hsel !== e_hsel) flag_mismatch("slave hsel", 64'(hsel), 64'(e_hsel));
      if (slv_ctrl !== e_ctrl) flag_mismatch("slave control", 64'(slv_ctrl), 64'(e_ctrl));
      for (int i = 0; i < 2; i++) begin
         if (m_st[i] == S_DATA) begin
            e_wdata = mx_hwdata[i];
            e_resp = {hready, ahb_port_pkg::HRESP_OKAY, m_daddr ^ RD_KEY};
         end else begin
            e_resp = {(m_st[i] == S_IDLE), ahb_port_pkg::HRESP_OKAY, 32'h0};
         end
         if (mx_resp[i] !== e_resp) flag_mismatch($sformatf("master %0d response", i),
                                                  64'(mx_resp[i]), 64'(e_resp));
         seen_rdy[i] = mx_resp[i].hready;
      end
      if (hwdata !== e_wdata) flag_mismatch("hwdata", 64'(hwdata), 64'(e_wdata));
      // slave latches the address of each accepted phase
      slv_addr_n = (hready && slv_ctrl.htrans != 2'b00) ? slv_ctrl.haddr : slv_addr_q;
   endtask

   // one clock: advance the model, drive after the edge, check late in the cycle
   task automatic run_cycle();
      @(posedge hclk);
      m_st = n_st;
      m_hsel_q = n_hsel_q;
      m_ctrl_q = n_ctrl_q;
      m_last = n_last;
      m_daddr = n_daddr;
      slv_addr_q = slv_addr_n;
      #1;
      for (int i = 0; i < 2; i++) begin
         mx_hsel[i] = st_hsel[i];
         mx_ctrl[i] = st_ctrl[i];
         mx_hready_in[i] = st_rdy_in[i];
         mx_hwdata[i] = xorshift();
         priority_level[i] = st_prio[i];
      end
      round_robin = st_rr;
      hready = (xorshift() % 100) >= wait_pct;
      hrdata = slv_addr_q ^ RD_KEY;
      #7;
      predict_and_check();
   endtask

   task automatic end_test(input string name);
      $display("test %s done, %0d errors", name, test_err);
      test_err = 0;
   endtask

   int b;
   int prev_owner;

   initial begin
      rng = 32'd6911;
      errors = 0;
      checks = 0;
      test_err = 0;
      resetn = 1'b0;
      round_robin = 1'b0;
      hready = 1'b1;
      hresp = ahb_port_pkg::HRESP_OKAY;
      hrdata = '0;
      st_rr = 1'b0;
      wait_pct = 0;
      for (int i = 0; i < 2; i++) begin
         {mx_hsel[i], mx_ctrl[i], mx_hwdata[i]} = '0;
         mx_hready_in[i] = 1'b1;
         priority_level[i] = '0;
         {st_hsel[i], st_ctrl[i], st_prio[i]} = '0;
         st_rdy_in[i] = 1'b1;
         seen_rdy[i] = 1'b1;
         m_st[i] = S_IDLE;
         n_st[i] = S_IDLE;
         {m_hsel_q[i], n_hsel_q[i], m_ctrl_q[i], n_ctrl_q[i]} = '0;
      end
      m_last = 1;
      n_last = 1;
      {m_daddr, n_daddr, slv_addr_q, slv_addr_n} = '0;
      repeat (2) @(posedge hclk);
      #1 resetn = 1'b1;

      // reset and idle
      repeat (6) run_cycle();
      if (hsel !== 2'b00 || slv_ctrl.htrans !== 2'b00) begin
         $display("slave bus not idle after reset");
         errors++;
         test_err++;
      end
      end_test("reset_idle");

      // single master through random wait states
      wait_pct = 30;
      repeat (60) begin
         offer(0, 2'b01 << (xorshift() & 1), ((xorshift() % 4) != 0) ? 2'b10 : 2'b00);
         run_cycle();
      end
      end_test("pass_through");

      // fixed priority, loser goes idle while its copy waits
      repeat (8) begin
         st_prio[0] = xorshift() & 1;
         st_prio[1] = xorshift() & 1;
         offer(0, 2'b01, 2'b10);
         offer(1, 2'b10, 2'b10);
         run_cycle();
         repeat (10) begin
            offer(0, 2'b00, 2'b00);
            offer(1, 2'b00, 2'b00);
            run_cycle();
         end
      end
      end_test("fixed_priority");

      // round robin with both masters always asking
      // each master uses its own slave select so hsel names the owner
      st_rr = 1'b1;
      prev_owner = -1;
      repeat (80) begin
         offer(0, 2'b01, 2'b10);
         offer(1, 2'b10, 2'b10);
         run_cycle();
         if (hready && slv_ctrl.htrans != 2'b00) begin
            if (int'(hsel[1]) == prev_owner) begin
               $display("round robin gave master %0d two phases in a row", hsel[1]);
               errors++;
               test_err++;
            end
            prev_owner = hsel[1];
         end
      end
      end_test("round_robin");

      // low-priority burst against a higher-priority competitor
      st_rr = 1'b0;
      st_prio[0] = 1'b0;
      st_prio[1] = 1'b1;
      wait_pct = 25;
      prev_owner = -1;
      repeat (4) begin
         b = 0;
         repeat (24) begin
            if (seen_rdy[0]) b++;
            case (b)
               1: offer(0, 2'b01, 2'b10);
               2, 4, 5: offer(0, 2'b01, 2'b11);
               3: offer(0, 2'b01, 2'b01);
               default: offer(0, 2'b00, 2'b00);
            endcase
            offer(1, 2'b10, (b >= 2) ? 2'b10 : 2'b00);
            run_cycle();
            if (hready && slv_ctrl.htrans != 2'b00) begin
               // master 1 may not take a phase while master 0 owns and continues its burst
               if (hsel[1] && prev_owner == 0 && mx_ctrl[0].htrans[0]) begin
                  $display("burst of master 0 was broken by master 1 at %0t", $time);
                  errors++;
                  test_err++;
               end
               prev_owner = hsel[1];
            end
         end
      end
      end_test("burst_hold");

      // everything random
      repeat (340) begin
         if ((xorshift() % 50) == 0) st_rr = xorshift() & 1;
         for (int i = 0; i < 2; i++) begin
            // one-hot select, or none when the shift runs past both bits
            offer(i, 2'b01 << (xorshift() % 3), 2'(xorshift()));
            st_prio[i] = xorshift() & 1;
            st_rdy_in[i] = (xorshift() % 10) != 0;
         end
         wait_pct = xorshift() % 50;
         run_cycle();
      end
      end_test("random_mix");

      // failed assertions of the bound checker count as errors
      errors += DUT.u_properties.fail_cnt;
      $display("tests 6, checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// ==== ahb_slave_port.f ====
verilog/ahb_port_pkg.sv
verilog/port_arbiter.sv
verilog/master_path_fsm.sv
verilog/ctrl_hold_mux.sv
verilog/resp_route.sv
verilog/ahb_slave_port.sv
test/ahb_slave_port_properties.sv
test/tb_ahb_slave_port.sv
